// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= int_block_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== alu.sv ====
`include "core_define_settings.svh"

module alu import core_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_squash_vld,
    input  logic             i_issue_vld,
    input  iqEntry_t         i_issue_entry,
    output iprIdx_t          o_rs_idx0,
    output iprIdx_t          o_rs_idx1,
    input  logic [`XLEN-1:0] i_rs_data0,
    input  logic [`XLEN-1:0] i_rs_data1,
    output logic             o_wb_vld,
    output valwbInfo_t       o_wb_info
);

    localparam int SHAMT_W = $clog2(`XLEN);

    logic              s1_vld;
    alu_op_t           s1_op;
    iprIdx_t           s1_rd;
    logic [`IMM_W-1:0] s1_imm;
    logic [`XLEN-1:0]  s1_a;
    logic [`XLEN-1:0]  s1_b;
    logic [`XLEN-1:0]  imm_ext;
    logic [`XLEN-1:0]  result;

    // stage 1 reads the regfile in the issue cycle
    assign o_rs_idx0 = i_issue_entry.dq.rs1;
    assign o_rs_idx1 = i_issue_entry.dq.rs2;

    always_ff @(posedge i_clk) begin
        if (i_rst || i_squash_vld) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= i_issue_vld;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_issue_vld) begin
            s1_op  <= i_issue_entry.dq.op;
            s1_rd  <= i_issue_entry.dq.rd;
            s1_imm <= i_issue_entry.dq.imm;
            s1_a   <= i_rs_data0;
            s1_b   <= i_rs_data1;
        end
    end

    assign imm_ext = {{(`XLEN - `IMM_W){s1_imm[`IMM_W-1]}}, s1_imm};

    // stage 2 execute
    always_comb begin
        case (s1_op)
            ADD:     result = s1_a + s1_b;
            SUB:     result = s1_a - s1_b;
            AND:     result = s1_a & s1_b;
            OR:      result = s1_a | s1_b;
            XOR:     result = s1_a ^ s1_b;
            SLL:     result = s1_a << s1_b[SHAMT_W-1:0];
            SRL:     result = s1_a >> s1_b[SHAMT_W-1:0];
            ADDI:    result = s1_a + imm_ext;
            default: result = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || i_squash_vld) begin
            o_wb_vld <= 1'b0;
        end else begin
            o_wb_vld <= s1_vld;
        end
    end

    always_ff @(posedge i_clk) begin
        if (s1_vld) begin
            o_wb_info <= '{rd: s1_rd, data: result};
        end
    end

endmodule

// ==== core_define_settings.svh ====
`ifndef CORE_DEFINE_SETTINGS_SVH
`define CORE_DEFINE_SETTINGS_SVH

// physical register count, register 0 reads as zero
`define PREG_NUM 64

// issue queue slots
`define IQ_DEPTH 8

// datapath width
`define XLEN 32

// immediate width, sign-extended in the ALU
`define IMM_W 12

`endif

// ==== core_pkg.sv ====
`include "core_define_settings.svh"

package core_pkg;

    typedef logic [$clog2(`PREG_NUM)-1:0] iprIdx_t;

    // ADDI uses the immediate in place of source 2
    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        OR   = 3'd3,
        XOR  = 3'd4,
        SLL  = 3'd5,
        SRL  = 3'd6,
        ADDI = 3'd7
    } alu_op_t;

    typedef struct packed {
        alu_op_t           op;
        iprIdx_t           rs1;
        iprIdx_t           rs2;
        iprIdx_t           rd;
        logic [`IMM_W-1:0] imm;
    } intDQEntry_t;

    typedef struct packed {
        intDQEntry_t dq;
        logic        rs1_rdy;
        logic        rs2_rdy;
    } iqEntry_t;

    typedef struct packed {
        iprIdx_t          rd;
        logic [`XLEN-1:0] data;
    } valwbInfo_t;

endpackage

// ==== int_block.sv ====
`include "core_define_settings.svh"

module int_block import core_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_squash_vld,
    input  logic              i_disp_vld,
    input  alu_op_t           i_disp_op,
    input  iprIdx_t           i_disp_rs1,
    input  iprIdx_t           i_disp_rs2,
    input  iprIdx_t           i_disp_rd,
    input  logic [`IMM_W-1:0] i_disp_imm,
    output logic              o_iq_full,
    output logic              o_wb_vld,
    output iprIdx_t           o_wb_rd,
    output logic [`XLEN-1:0]  o_wb_data
);

    iq_enq_if enq_if ();

    intDQEntry_t      disp_info;
    logic             issue_vld;
    iqEntry_t         issue_entry;
    iprIdx_t          rs_idx0;
    iprIdx_t          rs_idx1;
    logic [`XLEN-1:0] rs_data0;
    logic [`XLEN-1:0] rs_data1;
    logic             wb_vld;
    valwbInfo_t       wb_info;

    assign disp_info = '{op: i_disp_op, rs1: i_disp_rs1, rs2: i_disp_rs2,
                         rd: i_disp_rd, imm: i_disp_imm};

    int_dispatch u_int_dispatch (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_squash_vld (i_squash_vld),
        .i_disp_vld   (i_disp_vld),
        .i_disp_info  (disp_info),
        .i_wb_vld     (wb_vld),
        .i_wb_info    (wb_info),
        .enq          (enq_if.producer)
    );

    issue_que u_issue_que (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_squash_vld  (i_squash_vld),
        .enq           (enq_if.buffer),
        .i_wb_vld      (wb_vld),
        .i_wb_rdIdx    (wb_info.rd),
        .o_issue_vld   (issue_vld),
        .o_issue_entry (issue_entry)
    );

    int_regfile u_int_regfile (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rd_idx0  (rs_idx0),
        .i_rd_idx1  (rs_idx1),
        .o_rd_data0 (rs_data0),
        .o_rd_data1 (rs_data1),
        .i_wr_vld   (wb_vld),
        .i_wr_idx   (wb_info.rd),
        .i_wr_data  (wb_info.data)
    );

    alu u_alu (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_squash_vld  (i_squash_vld),
        .i_issue_vld   (issue_vld),
        .i_issue_entry (issue_entry),
        .o_rs_idx0     (rs_idx0),
        .o_rs_idx1     (rs_idx1),
        .i_rs_data0    (rs_data0),
        .i_rs_data1    (rs_data1),
        .o_wb_vld      (wb_vld),
        .o_wb_info     (wb_info)
    );

    assign o_iq_full = enq_if.full;
    assign o_wb_vld  = wb_vld;
    assign o_wb_rd   = wb_info.rd;
    assign o_wb_data = wb_info.data;

endmodule

// ==== int_block_properties.sv ====
module int_block_properties import core_pkg::*; (
    input logic     i_clk,
    input logic     i_rst,
    input logic     i_squash_vld,
    input logic     i_disp_vld,
    input logic     i_iq_full,
    input logic     i_issue_vld,
    input iqEntry_t i_issue_entry,
    input logic     i_wb_vld
);

    // dispatch holds back while every slot is taken
    no_enq_when_full: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_disp_vld && i_iq_full))
        else $error("dispatch strobe while the issue queue is full");

    issue_srcs_ready: assert property (@(posedge i_clk) disable iff (i_rst)
        i_issue_vld |-> (i_issue_entry.rs1_rdy && i_issue_entry.rs2_rdy))
        else $error("issued entry has a source not ready");

    // neither ALU stage nor the emptied queue may write back after a flush
    wb_quiet_after_flush: assert property (@(posedge i_clk)
        ($past(i_rst || i_squash_vld, 1) || $past(i_rst || i_squash_vld, 2)
         || $past(i_rst || i_squash_vld, 3)) |-> !i_wb_vld)
        else $error("o_wb_vld high within three cycles after reset or squash");

endmodule

bind int_block int_block_properties int_block_properties_i (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_squash_vld  (i_squash_vld),
    .i_disp_vld    (i_disp_vld),
    .i_iq_full     (o_iq_full),
    .i_issue_vld   (issue_vld),
    .i_issue_entry (issue_entry),
    .i_wb_vld      (o_wb_vld)
);

// ==== int_block_tb.sv ====
`include "core_define_settings.svh"

module int_block_tb import core_pkg::*; ();

    localparam int HIST_N = 16;

    logic              clk;
    logic              i_rst;
    logic              i_squash_vld;
    logic              i_disp_vld;
    alu_op_t           i_disp_op;
    iprIdx_t           i_disp_rs1;
    iprIdx_t           i_disp_rs2;
    iprIdx_t           i_disp_rd;
    logic [`IMM_W-1:0] i_disp_imm;
    logic              o_iq_full;
    logic              o_wb_vld;
    iprIdx_t           o_wb_rd;
    logic [`XLEN-1:0]  o_wb_data;

    // spec_rf holds every dispatched result
    logic [`XLEN-1:0] spec_rf [`PREG_NUM];
    // done_rf holds only written-back results
    logic [`XLEN-1:0] done_rf [`PREG_NUM];
    logic [`XLEN-1:0] exp_val [`PREG_NUM];
    logic             pending [`PREG_NUM];
    // recent destinations to pick sources from
    iprIdx_t          hist [HIST_N];
    int               hist_ptr;
    iprIdx_t          rd_ptr;
    iprIdx_t          last_rd;
    iprIdx_t          chain_rd;
    logic [31:0]      seed;
    int               chk_cnt;
    int               err_cnt;
    int               wb_cnt;

    int_block int_block_i (
        .i_clk        (clk),
        .i_rst        (i_rst),
        .i_squash_vld (i_squash_vld),
        .i_disp_vld   (i_disp_vld),
        .i_disp_op    (i_disp_op),
        .i_disp_rs1   (i_disp_rs1),
        .i_disp_rs2   (i_disp_rs2),
        .i_disp_rd    (i_disp_rd),
        .i_disp_imm   (i_disp_imm),
        .o_iq_full    (o_iq_full),
        .o_wb_vld     (o_wb_vld),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data)
    );

    always #2 clk = ~clk;

    function automatic int unsigned next_rand(input int unsigned range);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return (seed >> 16) % range;
    endfunction

    function automatic alu_op_t rand_op();
        return alu_op_t'(3'(next_rand(8)));
    endfunction

    function automatic logic [`IMM_W-1:0] rand_imm();
        return `IMM_W'(next_rand(1 << `IMM_W));
    endfunction

    // expected result of one op
    function automatic logic [`XLEN-1:0] ref_alu(input alu_op_t op, input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b,
                                                 input logic [`IMM_W-1:0] imm);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            default: return a + {{(`XLEN - `IMM_W){imm[`IMM_W-1]}}, imm};
        endcase
    endfunction

    function automatic int count_pending();
        int n;
        n = 0;
        for (int r = 0; r < `PREG_NUM; r++) begin
            if (pending[r]) begin
                n++;
            end
        end
        return n;
    endfunction

    // round robin over 1..63 that skips registers still in flight
    function automatic iprIdx_t alloc_rd();
        iprIdx_t r;
        r = rd_ptr;
        for (int i = 0; i < `PREG_NUM; i++) begin
            r = (r == iprIdx_t'(`PREG_NUM - 1)) ? iprIdx_t'(1) : r + iprIdx_t'(1);
            if (!pending[r]) begin
                break;
            end
        end
        rd_ptr = r;
        return r;
    endfunction

    function automatic iprIdx_t pick_src();
        if (next_rand(4) == 0) begin
            return '0;
        end
        return hist[next_rand(HIST_N)];
    endfunction

    task automatic check(input string name, input logic [`XLEN-1:0] got,
                         input logic [`XLEN-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic wait_not_full();
        int n;
        n = 0;
        while (o_iq_full && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (o_iq_full) begin
            $display("timeout: o_iq_full stayed high for 100 cycles");
            err_cnt++;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (count_pending() != 0 && n < 400) begin
            @(negedge clk);
            n++;
        end
        if (count_pending() != 0) begin
            $display("timeout: %0d ops never wrote back", count_pending());
            err_cnt++;
        end
    endtask

    task automatic dispatch(input alu_op_t op, input iprIdx_t rs1, input iprIdx_t rs2,
                            input logic [`IMM_W-1:0] imm);
        iprIdx_t rd;
        wait_not_full();
        rd = alloc_rd();
        exp_val[rd] = ref_alu(op, spec_rf[rs1], spec_rf[rs2], imm);
        spec_rf[rd] = exp_val[rd];
        pending[rd] = 1'b1;
        hist[hist_ptr] = rd;
        hist_ptr = (hist_ptr + 1) % HIST_N;
        last_rd = rd;
        i_disp_vld = 1'b1;
        i_disp_op = op;
        i_disp_rs1 = rs1;
        i_disp_rs2 = rs2;
        i_disp_rd = rd;
        i_disp_imm = imm;
        @(negedge clk);
        i_disp_vld = 1'b0;
    endtask

    task automatic squash();
        i_squash_vld = 1'b1;
        @(negedge clk);
        i_squash_vld = 1'b0;
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %-24s errors %0d", name, err_cnt - err_before);
    endtask

    // writeback compare and then squash bookkeeping at the same edge
    always @(posedge clk) begin
        if (!i_rst && o_wb_vld) begin
            wb_cnt++;
            if (!pending[o_wb_rd]) begin
                $display("writeback to register %0d with no op in flight", o_wb_rd);
                err_cnt++;
            end else begin
                check("o_wb_data", o_wb_data, exp_val[o_wb_rd]);
                done_rf[o_wb_rd] = exp_val[o_wb_rd];
                pending[o_wb_rd] = 1'b0;
            end
        end
        // killed ops fall back to the last written-back value
        if (!i_rst && i_squash_vld) begin
            for (int r = 0; r < `PREG_NUM; r++) begin
                if (pending[r]) begin
                    spec_rf[r] = done_rf[r];
                    pending[r] = 1'b0;
                end
            end
        end
    end

    initial begin
        int   err_before;
        int   n_flight;
        int   wb_before;
        logic full_seen;
        clk = 1'b0;
        i_rst = 1'b1;
        i_squash_vld = 1'b0;
        i_disp_vld = 1'b0;
        i_disp_op = ADD;
        i_disp_rs1 = '0;
        i_disp_rs2 = '0;
        i_disp_rd = '0;
        i_disp_imm = '0;
        seed = 32'hd14d;
        chk_cnt = 0;
        err_cnt = 0;
        wb_cnt = 0;
        hist_ptr = 0;
        rd_ptr = '0;
        n_flight = 0;
        for (int r = 0; r < `PREG_NUM; r++) begin
            spec_rf[r] = '0;
            done_rf[r] = '0;
            exp_val[r] = '0;
            pending[r] = 1'b0;
        end
        for (int i = 0; i < HIST_N; i++) begin
            hist[i] = '0;
        end
        repeat (3) @(negedge clk);
        i_rst = 1'b0;

        err_before = err_cnt;
        for (int i = 0; i < 12; i++) begin
            dispatch(ADDI, '0, '0, rand_imm());
            repeat (next_rand(3)) @(negedge clk);
        end
        drain();
        report_test("addi from r0", err_before);

        err_before = err_cnt;
        for (int i = 0; i < 30; i++) begin
            dispatch(rand_op(), pick_src(), pick_src(), rand_imm());
            repeat (next_rand(2)) @(negedge clk);
        end
        drain();
        report_test("random opcodes", err_before);

        // chain ops wait while independent ADDIs overtake them
        err_before = err_cnt;
        chain_rd = '0;
        for (int i = 0; i < 24; i++) begin
            if (next_rand(2) == 0) begin
                dispatch(rand_op(), chain_rd, pick_src(), rand_imm());
                chain_rd = last_rd;
            end else begin
                dispatch(ADDI, '0, '0, rand_imm());
            end
        end
        drain();
        report_test("dependent chains", err_before);

        err_before = err_cnt;
        chain_rd = '0;
        for (int i = 0; i < 5; i++) begin
            dispatch(rand_op(), chain_rd, pick_src(), rand_imm());
            chain_rd = last_rd;
        end
        full_seen = 1'b0;
        for (int i = 0; i < 2 * `IQ_DEPTH && !full_seen; i++) begin
            if (o_iq_full) begin
                full_seen = 1'b1;
                n_flight = count_pending();
            end else begin
                dispatch(rand_op(), chain_rd, chain_rd, rand_imm());
            end
        end
        check("o_iq_full", `XLEN'(full_seen), `XLEN'(1));
        // full queue plus at most one op in each ALU stage
        if (full_seen && (n_flight < `IQ_DEPTH || n_flight > `IQ_DEPTH + 2)) begin
            $display("o_iq_full rose with %0d ops in flight", n_flight);
            err_cnt++;
        end
        drain();
        report_test("queue full", err_before);

        err_before = err_cnt;
        chain_rd = '0;
        for (int i = 0; i < 6; i++) begin
            dispatch(rand_op(), chain_rd, pick_src(), rand_imm());
            chain_rd = last_rd;
        end
        squash();
        wb_before = wb_cnt;
        repeat (8) @(negedge clk);
        check("o_wb_vld count after squash", `XLEN'(wb_cnt - wb_before), '0);
        for (int i = 0; i < 20; i++) begin
            dispatch(rand_op(), pick_src(), pick_src(), rand_imm());
            repeat (next_rand(2)) @(negedge clk);
        end
        drain();
        report_test("squash", err_before);

        $display("checks %0d, errors %0d, writebacks %0d", chk_cnt, err_cnt, wb_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== int_dispatch.sv ====
`include "core_define_settings.svh"

module int_dispatch import core_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_squash_vld,
    input  logic        i_disp_vld,
    input  intDQEntry_t i_disp_info,
    input  logic        i_wb_vld,
    input  valwbInfo_t  i_wb_info,
    iq_enq_if.producer  enq
);

    // one ready bit per physical register
    logic [`PREG_NUM-1:0] sb_rdy;
    logic                 disp_take;
    logic                 rs1_rdy;
    logic                 rs2_rdy;

    // a strobe into a full queue is dropped before the scoreboard
    assign disp_take = i_disp_vld && !enq.full;

    // the queue only wakes stored entries so a same-cycle writeback is bypassed here
    assign rs1_rdy = sb_rdy[i_disp_info.rs1]
                   || (i_wb_vld && (i_wb_info.rd == i_disp_info.rs1));

    // ADDI has no second register source
    assign rs2_rdy = (i_disp_info.op == ADDI)
                   || sb_rdy[i_disp_info.rs2]
                   || (i_wb_vld && (i_wb_info.rd == i_disp_info.rs2));

    always_ff @(posedge i_clk) begin
        if (i_rst || i_squash_vld) begin
            sb_rdy <= '1;
        end else begin
            if (i_wb_vld) begin
                sb_rdy[i_wb_info.rd] <= 1'b1;
            end
            // register 0 never goes pending
            if (disp_take && (i_disp_info.rd != '0)) begin
                sb_rdy[i_disp_info.rd] <= 1'b0;
            end
        end
    end

    assign enq.enq_vld = disp_take;
    assign enq.entry   = '{dq: i_disp_info, rs1_rdy: rs1_rdy, rs2_rdy: rs2_rdy};

endmodule

// ==== int_regfile.sv ====
`include "core_define_settings.svh"

module int_regfile import core_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst,
    input  iprIdx_t          i_rd_idx0,
    input  iprIdx_t          i_rd_idx1,
    output logic [`XLEN-1:0] o_rd_data0,
    output logic [`XLEN-1:0] o_rd_data1,
    input  logic             i_wr_vld,
    input  iprIdx_t          i_wr_idx,
    input  logic [`XLEN-1:0] i_wr_data
);

    logic [`XLEN-1:0] regs [`PREG_NUM];

    // a same-cycle write is seen by the reader
    function automatic logic [`XLEN-1:0] read_port(input iprIdx_t idx);
        if (i_wr_vld && (i_wr_idx == idx) && (idx != '0)) begin
            return i_wr_data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `PREG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_vld && (i_wr_idx != '0)) begin
            // register 0 stays zero
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    assign o_rd_data0 = read_port(i_rd_idx0);
    assign o_rd_data1 = read_port(i_rd_idx1);

endmodule

// ==== iq_enq_if.sv ====
// dispatch to issue queue handshake
interface iq_enq_if import core_pkg::*; ();

    // one-cycle strobe, entry taken at the same edge
    logic     enq_vld;
    iqEntry_t entry;
    // every slot valid
    logic     full;

    modport producer (
        output enq_vld,
        output entry,
        input  full
    );

    modport buffer (
        input  enq_vld,
        input  entry,
        output full
    );

endinterface

// ==== issue_que.sv ====
`include "core_define_settings.svh"

module issue_que import core_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_squash_vld,
    iq_enq_if.buffer enq,
    input  logic     i_wb_vld,
    input  iprIdx_t  i_wb_rdIdx,
    output logic     o_issue_vld,
    output iqEntry_t o_issue_entry
);

    localparam int IDX_W = $clog2(`IQ_DEPTH);

    iqEntry_t             slot_q [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0] slot_vld;
    logic [`IQ_DEPTH-1:0] slot_rdy;
    logic [IDX_W-1:0]     free_idx;
    logic [IDX_W-1:0]     sel_idx;
    logic                 sel_found;

    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            slot_rdy[i] = slot_vld[i] && slot_q[i].rs1_rdy && slot_q[i].rs2_rdy;
        end
    end

    // scan from the top so the last hit is the lowest ready slot
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (slot_rdy[i]) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    // lowest free slot for the incoming entry
    always_comb begin
        free_idx = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (!slot_vld[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || i_squash_vld) begin
            slot_vld <= '0;
        end else begin
            // the selected slot is valid and the free slot is not so they never collide
            if (sel_found) begin
                slot_vld[sel_idx] <= 1'b0;
            end
            if (enq.enq_vld) begin
                slot_vld[free_idx] <= 1'b1;
            end
        end
    end

    // entry write and wakeup of stored sources
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (enq.enq_vld && (free_idx == IDX_W'(i))) begin
                slot_q[i] <= enq.entry;
            end else if (i_wb_vld) begin
                if (slot_q[i].dq.rs1 == i_wb_rdIdx) begin
                    slot_q[i].rs1_rdy <= 1'b1;
                end
                if (slot_q[i].dq.rs2 == i_wb_rdIdx) begin
                    slot_q[i].rs2_rdy <= 1'b1;
                end
            end
        end
    end

    assign enq.full      = &slot_vld;
    assign o_issue_vld   = sel_found;
    assign o_issue_entry = slot_q[sel_idx];

endmodule

// ==== verilog.f ====
+incdir+.
core_pkg.sv
iq_enq_if.sv
int_dispatch.sv
issue_que.sv
int_regfile.sv
alu.sv
int_block.sv
int_block_properties.sv
int_block_tb.sv
